/* src/mapper_consts.svh */
// task mapper sizing constants
// mesh, cluster and neighbor-window dimensions shared by every block

`ifndef MAPPER_CONSTS_SVH
`define MAPPER_CONSTS_SVH

// ############################################################
// mesh geometry
// ############################################################

// processing elements along one side of the full mesh
`define MESH_SIDE 8

// processing elements along one side of a cluster
`define CLUSTER_SIDE 4

// one main cluster plus three sub clusters
`define NUM_CLUSTERS 4

// PEs inside one cluster, including the controller corner
`define PE_PER_CLUSTER 16

// manhattan radius used when counting idle neighbors
`define NEIGHBOR_RADIUS 2

`endif

/* src/mapper_pkg.sv */
// task mapper shared types
// node ids, cluster indices, in-cluster coordinates and busy bookkeeping

`include "mapper_consts.svh"

package mapper_pkg;

  // node id on the full mesh, row * MESH_SIDE + col
  typedef logic [$clog2(`MESH_SIDE*`MESH_SIDE)-1:0] node_id_t;
  typedef logic [$clog2(`NUM_CLUSTERS)-1:0]         cluster_t;
  typedef logic [$clog2(`CLUSTER_SIDE)-1:0]         pe_coord_t;
  // needs to hold PE_PER_CLUSTER itself, hence the +1
  typedef logic [$clog2(`PE_PER_CLUSTER+1)-1:0]     busy_count_t;
  // one bit per PE, row-major inside the cluster
  typedef logic [`PE_PER_CLUSTER-1:0]               busy_map_t;

  // clusters 2 and 3 sit in the lower half of the mesh
  function automatic logic row_hi(input cluster_t c);
    return (c == cluster_t'(2)) || (c == cluster_t'(3));
  endfunction

  // clusters 1 and 2 sit in the right half of the mesh
  function automatic logic col_hi(input cluster_t c);
    return (c == cluster_t'(1)) || (c == cluster_t'(2));
  endfunction

  // mesh node id of a PE given its cluster and local row/col
  function automatic node_id_t to_node_id(input cluster_t c,
                                          input pe_coord_t row,
                                          input pe_coord_t col);
    return {row_hi(c), row, col_hi(c), col};
  endfunction

endpackage

/* src/occupancy_map.sv */
// occupancy map
// busy bit per PE for all four clusters, set on a grant and cleared on a
// release, with a combinational count of busy PEs per cluster

`include "mapper_consts.svh"

module occupancy_map (
  input  logic                    clk,
  input  logic                    root_task,
  input  logic                    grant_valid,
  input  mapper_pkg::node_id_t    grant_id,
  input  logic                    release_valid,
  input  mapper_pkg::node_id_t    release_id,
  output mapper_pkg::busy_map_t   busy_maps   [0:`NUM_CLUSTERS-1],
  output mapper_pkg::busy_count_t busy_counts [0:`NUM_CLUSTERS-1]
);

  import mapper_pkg::*;

  cluster_t  grant_cluster;
  pe_coord_t grant_row;
  pe_coord_t grant_col;
  cluster_t  release_cluster;
  pe_coord_t release_row;
  pe_coord_t release_col;

  // inverse of to_node_id: the top bit of the mesh row and col pick the quadrant
  function automatic cluster_t cluster_of(input node_id_t id);
    cluster_t c;
    case ({id[5], id[2]})
      2'b00:   c = cluster_t'(0);
      2'b01:   c = cluster_t'(1);
      2'b11:   c = cluster_t'(2);
      default: c = cluster_t'(3);
    endcase
    return c;
  endfunction

  // ############################################################
  // id decode
  // ############################################################

  assign grant_cluster   = cluster_of(grant_id);
  assign grant_row       = grant_id[4:3];
  assign grant_col       = grant_id[1:0];

  assign release_cluster = cluster_of(release_id);
  assign release_row     = release_id[4:3];
  assign release_col     = release_id[1:0];

  // ############################################################
  // busy bits
  // ############################################################

  // a grant always targets a free PE, so letting it win over a
  // release of the same PE only matters for a stray release
  always_ff @(posedge clk or negedge root_task) begin
    if (!root_task) begin
      for (int c = 0; c < `NUM_CLUSTERS; c++) begin
        busy_maps[c] <= '0;
      end
    end else begin
      if (release_valid) begin
        busy_maps[release_cluster][{release_row, release_col}] <= 1'b0;
      end
      if (grant_valid) begin
        busy_maps[grant_cluster][{grant_row, grant_col}] <= 1'b1;
      end
    end
  end

  // popcount per cluster
  always_comb begin
    for (int c = 0; c < `NUM_CLUSTERS; c++) begin
      busy_counts[c] = '0;
      for (int p = 0; p < `PE_PER_CLUSTER; p++) begin
        busy_counts[c] = busy_counts[c] + busy_count_t'(busy_maps[c][p]);
      end
    end
  end

endmodule

/* src/cluster_select.sv */
// cluster selector
// holds the active cluster and reloads it with the least-occupied cluster
// whenever an application ends

`include "mapper_consts.svh"

module cluster_select (
  input  logic                    clk,
  input  logic                    root_task,
  input  logic                    app_end,
  input  mapper_pkg::busy_count_t busy_counts [0:`NUM_CLUSTERS-1],
  output mapper_pkg::cluster_t    active_cluster
);

  import mapper_pkg::*;

  cluster_t    least_cluster;
  busy_count_t least_count;

  // ############################################################
  // least-occupied search
  // ############################################################

  // <= lets a later cluster take over on equal counts,
  // so ties end on the highest index
  always_comb begin
    least_cluster = cluster_t'(0);
    least_count   = busy_counts[0];
    for (int c = 1; c < `NUM_CLUSTERS; c++) begin
      if (busy_counts[c] <= least_count) begin
        least_cluster = cluster_t'(c);
        least_count   = busy_counts[c];
      end
    end
  end

  // ############################################################
  // active cluster register
  // ############################################################

  // a request in the app_end cycle still sees the old value
  always_ff @(posedge clk or negedge root_task) begin
    if (!root_task) begin
      active_cluster <= cluster_t'(0);
    end else if (app_end) begin
      active_cluster <= least_cluster;
    end
  end

endmodule

/* src/pe_picker.sv */
// PE picker
// scores every free PE of the active cluster and maps the request onto
// the best one; result strobe and ids appear one cycle after the request

`include "mapper_consts.svh"

module pe_picker (
  input  logic                  clk,
  input  logic                  root_task,
  input  logic                  task_valid,
  input  mapper_pkg::cluster_t  active_cluster,
  input  mapper_pkg::busy_map_t busy_maps [0:`NUM_CLUSTERS-1],
  output logic                  grant_valid,
  output mapper_pkg::node_id_t  grant_id,
  output logic                  map_valid,
  output logic                  map_fail,
  output mapper_pkg::node_id_t  src_id,
  output mapper_pkg::node_id_t  dest_id
);

  import mapper_pkg::*;

  // score fields, most significant decides first
  localparam int DIST_W = 3;
  localparam int IDLE_W = $clog2(`PE_PER_CLUSTER);
  localparam int IDX_W  = $clog2(`PE_PER_CLUSTER);
  localparam int KEY_W  = DIST_W + IDLE_W + IDX_W;

  busy_map_t         cur_map;
  pe_coord_t         corner_row;
  pe_coord_t         corner_col;
  logic [IDX_W-1:0]  corner_idx;
  node_id_t          corner_id;
  logic [IDLE_W-1:0] idle_cnt [0:`PE_PER_CLUSTER-1];
  logic              found;
  logic [IDX_W-1:0]  best_idx;

  // manhattan distance between two row-major positions of a cluster
  function automatic int manhattan(input int a, input int b);
    int dr;
    int dc;
    dr = a / `CLUSTER_SIDE - b / `CLUSTER_SIDE;
    dc = a % `CLUSTER_SIDE - b % `CLUSTER_SIDE;
    if (dr < 0) begin
      dr = -dr;
    end
    if (dc < 0) begin
      dc = -dc;
    end
    return dr + dc;
  endfunction

  // ############################################################
  // active cluster view
  // ############################################################

  assign cur_map = busy_maps[active_cluster];

  // controller sits on the cluster's outer mesh corner
  assign corner_row = {$bits(pe_coord_t){row_hi(active_cluster)}};
  assign corner_col = {$bits(pe_coord_t){col_hi(active_cluster)}};
  assign corner_idx = {corner_row, corner_col};
  assign corner_id  = to_node_id(active_cluster, corner_row, corner_col);

  // ############################################################
  // idle neighbors within NEIGHBOR_RADIUS
  // ############################################################

  // the corner PE is never mapped, so it always counts as idle
  always_comb begin
    logic [IDLE_W-1:0] acc;
    for (int p = 0; p < `PE_PER_CLUSTER; p++) begin
      acc = '0;
      for (int q = 0; q < `PE_PER_CLUSTER; q++) begin
        if (q != p && !cur_map[q] && manhattan(p, q) <= `NEIGHBOR_RADIUS) begin
          acc = acc + IDLE_W'(1);
        end
      end
      idle_cnt[p] = acc;
    end
  end

  // ############################################################
  // winner search
  // ############################################################

  // key = distance, then inverted idle count, then row-major index
  // counted from the controller corner; smallest key wins.
  // xor with the corner turns r into 3-r where the corner is on row 3
  always_comb begin
    logic [KEY_W-1:0] key;
    logic [KEY_W-1:0] best_key;
    found    = 1'b0;
    best_key = '1;
    best_idx = '0;
    for (int p = 0; p < `PE_PER_CLUSTER; p++) begin
      key = {DIST_W'(manhattan(p, int'(corner_idx))),
             ~idle_cnt[p],
             IDX_W'(p) ^ corner_idx};
      if (!cur_map[p] && IDX_W'(p) != corner_idx && (!found || key < best_key)) begin
        found    = 1'b1;
        best_key = key;
        best_idx = IDX_W'(p);
      end
    end
  end

  // grant goes straight to the occupancy map so the bit is set
  // at the same edge that shows the result
  assign grant_valid = task_valid & found;
  assign grant_id    = to_node_id(active_cluster,
                                  best_idx[IDX_W-1 -: $bits(pe_coord_t)],
                                  best_idx[$bits(pe_coord_t)-1:0]);

  // ############################################################
  // result registers
  // ############################################################

  always_ff @(posedge clk or negedge root_task) begin
    if (!root_task) begin
      map_valid <= 1'b0;
      map_fail  <= 1'b0;
      src_id    <= '0;
      dest_id   <= '0;
    end else begin
      map_valid <= grant_valid;
      map_fail  <= task_valid & ~found;
      if (task_valid) begin
        src_id  <= corner_id;
        // no destination on a fail
        dest_id <= found ? grant_id : '0;
      end
    end
  end

endmodule

/* src/task_mapper.sv */
// task mapper top level
// maps task requests onto PEs of an 8x8 mesh split into four clusters,
// tracking occupancy and moving to the least-busy cluster per application

`include "mapper_consts.svh"

module task_mapper (
  input  logic                 clk,
  input  logic                 root_task,
  input  logic                 task_valid,
  input  logic                 app_end,
  input  logic                 release_valid,
  input  mapper_pkg::node_id_t release_id,
  output logic                 map_valid,
  output logic                 map_fail,
  output mapper_pkg::node_id_t src_id,
  output mapper_pkg::node_id_t dest_id
);

  import mapper_pkg::*;

  busy_map_t   busy_maps   [0:`NUM_CLUSTERS-1];
  busy_count_t busy_counts [0:`NUM_CLUSTERS-1];
  cluster_t    active_cluster;
  logic        grant_valid;
  node_id_t    grant_id;

  // ############################################################
  // occupancy tracking
  // ############################################################

  occupancy_map u_occupancy_map (
    .clk           (clk),
    .root_task     (root_task),
    .grant_valid   (grant_valid),
    .grant_id      (grant_id),
    .release_valid (release_valid),
    .release_id    (release_id),
    .busy_maps     (busy_maps),
    .busy_counts   (busy_counts)
  );

  // switches cluster only at app_end
  cluster_select u_cluster_select (
    .clk            (clk),
    .root_task      (root_task),
    .app_end        (app_end),
    .busy_counts    (busy_counts),
    .active_cluster (active_cluster)
  );

  // ############################################################
  // mapping
  // ############################################################

  pe_picker u_pe_picker (
    .clk            (clk),
    .root_task      (root_task),
    .task_valid     (task_valid),
    .active_cluster (active_cluster),
    .busy_maps      (busy_maps),
    .grant_valid    (grant_valid),
    .grant_id       (grant_id),
    .map_valid      (map_valid),
    .map_fail       (map_fail),
    .src_id         (src_id),
    .dest_id        (dest_id)
  );

endmodule

/* sim/tb_clock_gen.sv */
// testbench clock source
// free-running clock, low at time zero

module tb_clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD / 2);
    clk = ~clk;
  end

endmodule

/* sim/task_mapper_checker.sv */
// task mapper result checker
// latches the expected result of each request and compares it with the
// DUT outputs one cycle later, counting value and strobe errors

module task_mapper_checker (
  input  logic                 clk,
  input  logic                 root_task,
  input  logic                 task_valid,
  input  logic                 exp_valid,
  input  logic                 exp_fail,
  input  mapper_pkg::node_id_t exp_src,
  input  mapper_pkg::node_id_t exp_dest,
  input  logic                 map_valid,
  input  logic                 map_fail,
  input  mapper_pkg::node_id_t src_id,
  input  mapper_pkg::node_id_t dest_id,
  output int                   value_errors,
  output int                   strobe_errors
);

  import mapper_pkg::*;

  logic     pending;
  logic     pend_valid;
  logic     pend_fail;
  node_id_t pend_src;
  node_id_t pend_dest;
  logic     seen_request;
  int       value_count = 0;
  int       strobe_count = 0;

  assign value_errors  = value_count;
  assign strobe_errors = strobe_count;

  task automatic check_strobe(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      strobe_count++;
      if (expected) begin
        $display("%s did not rise one cycle after a request", name);
      end else begin
        $display("%s rose when no such result was due", name);
      end
    end
  endtask

  task automatic check_value(input string name, input node_id_t expected, input node_id_t actual);
    if (actual !== expected) begin
      value_count++;
      $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  // ############################################################
  // capture at the edge where the DUT samples the request
  // ############################################################

  always @(posedge clk or negedge root_task) begin
    if (!root_task) begin
      pending      <= 1'b0;
      pend_valid   <= 1'b0;
      pend_fail    <= 1'b0;
      pend_src     <= '0;
      pend_dest    <= '0;
      seen_request <= 1'b0;
    end else begin
      pending    <= task_valid;
      pend_valid <= exp_valid;
      pend_fail  <= exp_fail;
      pend_src   <= exp_src;
      pend_dest  <= exp_dest;
      if (task_valid) begin
        seen_request <= 1'b1;
      end
    end
  end

  // ############################################################
  // compare half a cycle after the result edge
  // ############################################################

  always @(negedge clk) begin
    if (root_task) begin
      check_strobe("map_valid", pending & pend_valid, map_valid);
      check_strobe("map_fail", pending & pend_fail, map_fail);
      if (pending) begin
        check_value("src_id", pend_src, src_id);
        // dest only means something on a successful map
        if (pend_valid) begin
          check_value("dest_id", pend_dest, dest_id);
        end
      end else if (!seen_request) begin
        check_value("src_id", '0, src_id);
        check_value("dest_id", '0, dest_id);
      end
    end
  end

endmodule

/* sim/task_mapper_assertions.sv */
// task mapper protocol assertions
// strobe exclusivity, one result per request, quiet strobes during reset

module task_mapper_assertions (
  input logic clk,
  input logic root_task,
  input logic task_valid,
  input logic map_valid,
  input logic map_fail
);

  // a result is either a map or a fail, never both
  strobe_exclusive: assert property (@(posedge clk) !(map_valid && map_fail))
    else $error("map_valid and map_fail high together");

  one_result: assert property (@(posedge clk) disable iff (!root_task)
    task_valid |=> (map_valid ^ map_fail))
    else $error("request not answered by exactly one result strobe");

  quiet_in_reset: assert property (@(posedge clk) !root_task |-> !(map_valid || map_fail))
    else $error("result strobe high while in reset");

endmodule

bind task_mapper task_mapper_assertions u_assertions (
  .clk        (clk),
  .root_task  (root_task),
  .task_valid (task_valid),
  .map_valid  (map_valid),
  .map_fail   (map_fail)
);

/* sim/task_mapper_tb.sv */
// task mapper testbench
// applies a table of requests, releases and application ends on the
// falling clock edge and reports the checker's verdict

module task_mapper_tb;

  import mapper_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int SETTLE_CYCLES = 4;
  localparam int SLACK_CYCLES  = 8;

  typedef enum logic [1:0] {KIND_REQ, KIND_END, KIND_REQ_END, KIND_REL} kind_t;

  typedef struct packed {
    kind_t    kind;
    node_id_t rel_id;
    logic     exp_valid;
    logic     exp_fail;
    node_id_t exp_src;
    node_id_t exp_dest;
  } entry_t;

  logic     clk;
  logic     root_task;
  logic     task_valid;
  logic     app_end;
  logic     release_valid;
  node_id_t release_id;
  logic     map_valid;
  logic     map_fail;
  node_id_t src_id;
  node_id_t dest_id;
  logic     exp_valid;
  logic     exp_fail;
  node_id_t exp_src;
  node_id_t exp_dest;
  int       value_errors;
  int       strobe_errors;
  int       cycle_count = 0;
  int       cycle_limit;
  entry_t   table_q [$];

  tb_clock_gen #(.PERIOD(4)) u_clock_gen (.clk(clk));

  task_mapper u_dut (
    .clk           (clk),
    .root_task     (root_task),
    .task_valid    (task_valid),
    .app_end       (app_end),
    .release_valid (release_valid),
    .release_id    (release_id),
    .map_valid     (map_valid),
    .map_fail      (map_fail),
    .src_id        (src_id),
    .dest_id       (dest_id)
  );

  task_mapper_checker u_checker (
    .clk           (clk),
    .root_task     (root_task),
    .task_valid    (task_valid),
    .exp_valid     (exp_valid),
    .exp_fail      (exp_fail),
    .exp_src       (exp_src),
    .exp_dest      (exp_dest),
    .map_valid     (map_valid),
    .map_fail      (map_fail),
    .src_id        (src_id),
    .dest_id       (dest_id),
    .value_errors  (value_errors),
    .strobe_errors (strobe_errors)
  );

  task automatic add_entry(input kind_t kind, input int rel, input logic valid,
                           input logic fail, input int src, input int dest);
    entry_t e;
    e.kind      = kind;
    e.rel_id    = node_id_t'(rel);
    e.exp_valid = valid;
    e.exp_fail  = fail;
    e.exp_src   = node_id_t'(src);
    e.exp_dest  = node_id_t'(dest);
    table_q.push_back(e);
  endtask

  // ############################################################
  // stimulus table
  // ############################################################

  task automatic build_table();
    int c3_dests [12];
    // cluster 0 from empty: (0,1) and (1,0) tie, row-major picks 1
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 0, 1);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 0, 8);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 0, 9);
    // still cluster 0, then clusters 1..3 tie empty and 3 wins
    add_entry(KIND_REQ_END, 0, 1'b1, 1'b0, 0, 2);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 56, 57);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 56, 48);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 56, 49);
    // freed PE is the best choice again
    add_entry(KIND_REL, 49, 1'b0, 1'b0, 0, 0);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 56, 49);
    c3_dests = '{58, 40, 50, 41, 59, 32, 42, 51, 33, 43, 34, 35};
    foreach (c3_dests[i]) begin
      add_entry(KIND_REQ, 0, 1'b1, 1'b0, 56, c3_dests[i]);
    end
    // cluster 3 full apart from its controller
    add_entry(KIND_REQ, 0, 1'b0, 1'b1, 56, 0);
    // idle PE, nothing changes
    add_entry(KIND_REL, 60, 1'b0, 1'b0, 0, 0);
    // counts 4/0/0/15, tie between 1 and 2 goes to 2
    add_entry(KIND_END, 0, 1'b0, 1'b0, 0, 0);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 63, 62);
    add_entry(KIND_REQ_END, 0, 1'b1, 1'b0, 63, 55);
    add_entry(KIND_REQ, 0, 1'b1, 1'b0, 7, 6);
  endtask

  task automatic apply_entry(input entry_t e);
    task_valid    = (e.kind == KIND_REQ) || (e.kind == KIND_REQ_END);
    app_end       = (e.kind == KIND_END) || (e.kind == KIND_REQ_END);
    release_valid = (e.kind == KIND_REL);
    release_id    = e.rel_id;
    exp_valid     = e.exp_valid;
    exp_fail      = e.exp_fail;
    exp_src       = e.exp_src;
    exp_dest      = e.exp_dest;
  endtask

  task automatic clear_inputs();
    task_valid    = 1'b0;
    app_end       = 1'b0;
    release_valid = 1'b0;
    release_id    = '0;
    exp_valid     = 1'b0;
    exp_fail      = 1'b0;
    exp_src       = '0;
    exp_dest      = '0;
  endtask

  // ############################################################
  // run and verdict
  // ############################################################

  initial begin
    clear_inputs();
    root_task = 1'b0;
    build_table();
    cycle_limit = 2 * table_q.size() + RESET_CYCLES + SETTLE_CYCLES + SLACK_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    root_task = 1'b1;
    // quiet window right after reset
    repeat (SETTLE_CYCLES) @(negedge clk);
    for (int i = 0; i < table_q.size(); i++) begin
      apply_entry(table_q[i]);
      @(negedge clk);
      clear_inputs();
      @(negedge clk);
    end
    @(posedge clk);
    $display("checks done: %0d value errors, %0d strobe errors", value_errors, strobe_errors);
    if (value_errors == 0 && strobe_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

/* task_mapper.f */
+incdir+src
src/mapper_pkg.sv
src/occupancy_map.sv
src/cluster_select.sv
src/pe_picker.sv
src/task_mapper.sv
sim/tb_clock_gen.sv
sim/task_mapper_checker.sv
sim/task_mapper_assertions.sv
sim/task_mapper_tb.sv

/* Makefile */
# task mapper simulation with Verilator

TOP := task_mapper_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f task_mapper.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
